// ==== Bender.yml ====
package:
  name: msgbank

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - msgbank_msg_pkg.sv
      - msgbank_store_pkg.sv
      - msgbank_slot_store.sv
      - msgbank_slot_alloc.sv
      - msgbank_list_ctrl.sv
      - msgbank_release_arb.sv
      - msgbank_top.sv
      - target: test
        files:
          - msgbank_checker.sv
          - tb_msgbank.sv

// ==== msgbank_checker.sv ====
// ####################################################################
// Concurrent assertions on the message bank ports. Attached to every
// msgbank_top instance with bind when the testbench files are built.
// ####################################################################

`timescale 1ns/1ps

module msgbank_checker
  import msgbank_msg_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     in_valid_i,
  input logic     in_ready_o,
  input msg_t     in_msg_i,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input msg_t     out_msg_o,
  input id_mask_t release_en_i
);

  logic push_lower;

  // A push to a lower identifier may take over the pick on the next cycle
  assign push_lower = in_valid_i && in_ready_o && (in_msg_i.id < out_msg_o.id);

  out_enabled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> release_en_i[out_msg_o.id])
    else $error("Output identifier is not release-enabled");

  ready_after_reset_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> in_ready_o)
    else $error("Input not ready in the first cycle after reset");

  out_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i && !push_lower) ##1 $stable(release_en_i)
      |-> $stable(out_msg_o))
    else $error("Output message changed while stalled");

endmodule

bind msgbank_top msgbank_checker u_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .in_valid_i   (in_valid_i),
  .in_ready_o   (in_ready_o),
  .in_msg_i     (in_msg_i),
  .out_valid_o  (out_valid_o),
  .out_ready_i  (out_ready_i),
  .out_msg_o    (out_msg_o),
  .release_en_i (release_en_i)
);

// ==== msgbank_list_ctrl.sv ====
// ####################################################################
// Per-identifier linked lists over the shared slots. Holds head, tail
// and length of each list plus the payload and next-pointer stores.
// ####################################################################

`timescale 1ns/1ps

module msgbank_list_ctrl
  import msgbank_msg_pkg::*;
  import msgbank_store_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Push from the input side
  input  slot_write_t write_i,

  // Pop command and selected identifier from the output side
  input  release_t    release_i,

  output id_mask_t    nonempty_o,
  output msg_t        head_msg_o,

  // Slot emptied by the pop
  output slot_free_t  free_o
);

  localparam int NumIds = $bits(id_mask_t);

  slot_addr_t   head_d [NumIds];
  slot_addr_t   head_q [NumIds];
  slot_addr_t   tail_d [NumIds];
  slot_addr_t   tail_q [NumIds];
  list_len_t    len_d  [NumIds];
  list_len_t    len_q  [NumIds];

  id_mask_t     push_mask, pop_mask;
  slot_addr_t   head_sel;
  slot_addr_t   head_next;
  msg_payload_t head_payload;
  logic         next_wr_en;

  assign push_mask = write_i.valid ? id_mask_t'(1) << write_i.id : '0;
  assign pop_mask  = release_i.valid ? id_mask_t'(1) << release_i.id : '0;

  // Head of the list the arbiter currently points at
  assign head_sel = head_q[release_i.id];

  always_comb begin
    head_d     = head_q;
    tail_d     = tail_q;
    len_d      = len_q;
    next_wr_en = 1'b0;
    for (int i = 0; i < NumIds; i++) begin
      if (pop_mask[i]) begin
        head_d[i] = head_next;
      end
      if (push_mask[i]) begin
        tail_d[i] = write_i.addr;
        // List is or becomes empty, so the new slot starts it afresh
        if (len_q[i] == '0 || (len_q[i] == list_len_t'(1) && pop_mask[i])) begin
          head_d[i] = write_i.addr;
        end else begin
          next_wr_en = 1'b1;
        end
      end
      len_d[i] = len_q[i] + list_len_t'(push_mask[i]) - list_len_t'(pop_mask[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        len_q[i]  <= '0;
      end
    end else begin
      head_q <= head_d;
      tail_q <= tail_d;
      len_q  <= len_d;
    end
  end

  for (genvar i = 0; i < NumIds; i++) begin : gen_nonempty
    assign nonempty_o[i] = len_q[i] != '0;
  end

  msgbank_slot_store #(
    .entry_t (msg_payload_t)
  ) u_msg_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (write_i.valid),
    .wr_addr_i (write_i.addr),
    .wr_data_i (write_i.payload),
    .rd_addr_i (head_sel),
    .rd_data_o (head_payload)
  );

  // Links the old tail to the newly pushed slot
  msgbank_slot_store #(
    .entry_t (slot_addr_t)
  ) u_next_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (next_wr_en),
    .wr_addr_i (tail_q[write_i.id]),
    .wr_data_i (write_i.addr),
    .rd_addr_i (head_sel),
    .rd_data_o (head_next)
  );

  assign head_msg_o = '{payload: head_payload, id: release_i.id};
  assign free_o     = '{valid: release_i.valid, addr: head_sel};

endmodule

// ==== msgbank_msg_pkg.sv ====
// ####################################################################
// Message format of the bank. Import this in every block that handles
// messages or per-identifier masks.
// ####################################################################

`include "msgbank_params.svh"

package msgbank_msg_pkg;

  // Identifier of a message, selects its list
  typedef logic [`MSGBANK_ID_WIDTH-1:0] msg_id_t;

  // Message content without the identifier
  typedef logic [`MSGBANK_PAYLOAD_WIDTH-1:0] msg_payload_t;

  // Full message as seen on the streams, identifier in the low bits
  typedef struct packed {
    msg_payload_t payload;
    msg_id_t      id;
  } msg_t;

  // One bit per identifier
  typedef logic [2**`MSGBANK_ID_WIDTH-1:0] id_mask_t;

endpackage

// ==== msgbank_params.svh ====
// ####################################################################
// Size settings for the message bank. Include this file wherever the
// identifier width, slot count or payload width is needed.
// ####################################################################

`ifndef MSGBANK_PARAMS_SVH
`define MSGBANK_PARAMS_SVH

// Identifier bits at the bottom of each message, one list per value
`define MSGBANK_ID_WIDTH 2

// Slots shared by all lists
`define MSGBANK_CAPACITY 16

// Message bits above the identifier
`define MSGBANK_PAYLOAD_WIDTH 12

`endif

// ==== msgbank_release_arb.sv ====
// ####################################################################
// Output side of the bank. Picks the lowest identifier that is both
// enabled and non-empty, drives the output stream and issues the pop.
// ####################################################################

`timescale 1ns/1ps

module msgbank_release_arb
  import msgbank_msg_pkg::*;
  import msgbank_store_pkg::*;
(
  input  id_mask_t nonempty_i,
  input  id_mask_t release_en_i,
  input  msg_t     head_msg_i,

  // Output stream
  input  logic     out_ready_i,
  output logic     out_valid_o,
  output msg_t     out_msg_o,

  // Pop command, the id always follows the current pick
  output release_t release_o
);

  localparam int NumIds = $bits(id_mask_t);

  id_mask_t candidates;
  msg_id_t  pick_id;

  assign candidates = nonempty_i & release_en_i;

  // Fixed priority, lowest identifier wins
  always_comb begin
    pick_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (candidates[i]) begin
        pick_id = msg_id_t'(i);
      end
    end
  end

  assign out_valid_o = |candidates;

  // List side already tags the head payload with the picked id
  assign out_msg_o = head_msg_i;

  assign release_o = '{valid: out_valid_o && out_ready_i, id: pick_id};

endmodule

// ==== msgbank_slot_alloc.sv ====
// ####################################################################
// Input side of the bank. Tracks which slots hold a message, offers
// the lowest free slot and turns an input transfer into a write.
// ####################################################################

`timescale 1ns/1ps

`include "msgbank_params.svh"

module msgbank_slot_alloc
  import msgbank_msg_pkg::*;
  import msgbank_store_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Input stream
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  msg_t        in_msg_i,

  // Slot released by a pop
  input  slot_free_t  free_i,

  // Write request towards the lists
  output slot_write_t write_o
);

  logic [`MSGBANK_CAPACITY-1:0] occupied_d, occupied_q;
  slot_addr_t                   free_slot;
  logic                         in_xfer;

  // Lowest free slot, scanned from the top so the last hit wins
  always_comb begin
    free_slot = '0;
    for (int i = `MSGBANK_CAPACITY - 1; i >= 0; i--) begin
      if (!occupied_q[i]) begin
        free_slot = slot_addr_t'(i);
      end
    end
  end

  // Ready only depends on the bitmap
  assign in_ready_o = ~&occupied_q;
  assign in_xfer    = in_valid_i && in_ready_o;

  assign write_o = '{
    valid:   in_xfer,
    addr:    free_slot,
    payload: in_msg_i.payload,
    id:      in_msg_i.id
  };

  // Alloc and free never hit the same slot, the free one is occupied
  always_comb begin
    occupied_d = occupied_q;
    if (free_i.valid) begin
      occupied_d[free_i.addr] = 1'b0;
    end
    if (in_xfer) begin
      occupied_d[free_slot] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

endmodule

// ==== msgbank_slot_store.sv ====
// ####################################################################
// Slot storage as a register array. One write port on the clock edge,
// one combinational read port. The entry type is set per instance.
// ####################################################################

`timescale 1ns/1ps

`include "msgbank_params.svh"

module msgbank_slot_store
  import msgbank_store_pkg::*;
#(
  parameter type entry_t = logic
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       wr_en_i,
  input  slot_addr_t wr_addr_i,
  input  entry_t     wr_data_i,

  input  slot_addr_t rd_addr_i,
  output entry_t     rd_data_o
);

  entry_t mem_q [`MSGBANK_CAPACITY];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `MSGBANK_CAPACITY; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Read sees the old contents during a write to the same slot
  assign rd_data_o = mem_q[rd_addr_i];

endmodule

// ==== msgbank_store_pkg.sv ====
// ####################################################################
// Storage bookkeeping types: slot addresses, list lengths and the
// requests that move between input side, lists and output side.
// ####################################################################

`include "msgbank_params.svh"

package msgbank_store_pkg;
  import msgbank_msg_pkg::*;

  typedef logic [$clog2(`MSGBANK_CAPACITY)-1:0] slot_addr_t;

  // Needs one more value than slots, a list may hold them all
  typedef logic [$clog2(`MSGBANK_CAPACITY+1)-1:0] list_len_t;

  // Write request from the input side, valid is the input transfer
  typedef struct packed {
    logic         valid;
    slot_addr_t   addr;
    msg_payload_t payload;
    msg_id_t      id;
  } slot_write_t;

  // Slot emptied by a pop
  typedef struct packed {
    logic       valid;
    slot_addr_t addr;
  } slot_free_t;

  // Pop command from the output side
  typedef struct packed {
    logic    valid;
    msg_id_t id;
  } release_t;

endpackage

// ==== msgbank_top.f ====
+incdir+.
msgbank_msg_pkg.sv
msgbank_store_pkg.sv
msgbank_slot_store.sv
msgbank_slot_alloc.sv
msgbank_list_ctrl.sv
msgbank_release_arb.sv
msgbank_top.sv
msgbank_checker.sv
tb_msgbank.sv

// ==== msgbank_top.sv ====
// ####################################################################
// Message bank top level. Messages enter on one valid/ready stream,
// wait in per-identifier lists and leave on a second stream when
// their identifier is release-enabled.
// ####################################################################

`timescale 1ns/1ps

module msgbank_top
  import msgbank_msg_pkg::*;
  import msgbank_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  msg_t     in_msg_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output msg_t     out_msg_o,

  input  id_mask_t release_en_i
);

  slot_write_t slot_write;
  slot_free_t  slot_free;
  release_t    release_cmd;
  id_mask_t    nonempty;
  msg_t        head_msg;

  msgbank_slot_alloc u_slot_alloc (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_msg_i   (in_msg_i),
    .free_i     (slot_free),
    .write_o    (slot_write)
  );

  msgbank_list_ctrl u_list_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .write_i    (slot_write),
    .release_i  (release_cmd),
    .nonempty_o (nonempty),
    .head_msg_o (head_msg),
    .free_o     (slot_free)
  );

  msgbank_release_arb u_release_arb (
    .nonempty_i   (nonempty),
    .release_en_i (release_en_i),
    .head_msg_i   (head_msg),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_msg_o    (out_msg_o),
    .release_o    (release_cmd)
  );

endmodule

// ==== tb_msgbank.sv ====
// ####################################################################
// Testbench for the message bank. Drives random and directed traffic
// into msgbank_top and checks every cycle against a queue model.
// ####################################################################

`timescale 1ns/1ps

`include "msgbank_params.svh"

module tb_msgbank
  import msgbank_msg_pkg::*;
();

  localparam int num_ids       = $bits(id_mask_t);
  localparam int capacity      = `MSGBANK_CAPACITY;
  localparam int random_cycles = 3000;
  localparam int wait_limit    = 400;
  localparam logic [31:0] seed = 32'hcbcc_b3eb;

  logic     clk_i;
  logic     rst_ni;
  logic     in_valid_i;
  logic     in_ready_o;
  msg_t     in_msg_i;
  logic     out_valid_o;
  logic     out_ready_i;
  msg_t     out_msg_o;
  id_mask_t release_en_i;

  // Expected contents of each identifier's list, front leaves first
  msg_t model_q [num_ids][$];
  int   held;

  msgbank_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_msg_i     (in_msg_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_msg_o    (out_msg_o),
    .release_en_i (release_en_i)
  );

  always #10 clk_i = ~clk_i;

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare(input string test_name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    abort_run();
  endtask

  function automatic msg_t make_msg(input msg_payload_t payload, input msg_id_t id);
    msg_t m;
    m.payload = payload;
    m.id      = id;
    return m;
  endfunction

  function automatic msg_t random_msg();
    return make_msg(msg_payload_t'($urandom), msg_id_t'($urandom));
  endfunction

  function automatic int queued(input id_mask_t en);
    int total;
    total = 0;
    for (int i = 0; i < num_ids; i++) begin
      if (en[i]) begin
        total += model_q[i].size();
      end
    end
    return total;
  endfunction

  // Outputs are settled at the falling edge; the model then takes
  // the transfers of the coming rising edge
  task automatic check_cycle();
    logic    exp_valid;
    logic    room;
    msg_id_t exp_id;
    exp_valid = 1'b0;
    exp_id    = '0;
    room      = held < capacity;
    for (int i = num_ids - 1; i >= 0; i--) begin
      if (release_en_i[i] && model_q[i].size() != 0) begin
        exp_valid = 1'b1;
        exp_id    = msg_id_t'(i);
      end
    end
    compare("in_ready", room, in_ready_o);
    compare("out_valid", exp_valid, out_valid_o);
    if (exp_valid) begin
      compare("out_msg", model_q[exp_id][0], out_msg_o);
      if (out_ready_i) begin
        void'(model_q[exp_id].pop_front());
        held--;
      end
    end
    if (in_valid_i && room) begin
      model_q[in_msg_i.id].push_back(in_msg_i);
      held++;
    end
  endtask

  task automatic step(input logic in_valid, input msg_t in_msg, input logic out_ready,
                      input id_mask_t release_en);
    @(posedge clk_i);
    #2;
    in_valid_i   = in_valid;
    in_msg_i     = in_msg;
    out_ready_i  = out_ready;
    release_en_i = release_en;
    @(negedge clk_i);
    check_cycle();
  endtask

  task automatic wait_drained(input id_mask_t en);
    int waited;
    waited = 0;
    while (queued(en) != 0) begin
      if (waited == wait_limit) begin
        report_timeout("queued messages did not leave the bank");
      end
      step(1'b0, '0, 1'b1, en);
      waited++;
    end
  endtask

  initial begin
    int          ready_pct;
    msg_t        msg_a;
    msg_t        msg_b;
    msg_id_t     gated_id;
    id_mask_t    gated_mask;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_msg_i     = '0;
    out_ready_i  = 1'b0;
    release_en_i = '0;
    held         = 0;
    void'($urandom(seed));
    gated_id     = msg_id_t'(num_ids - 1);
    gated_mask   = id_mask_t'(1) << gated_id;

    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare("reset_out_valid", 1'b0, out_valid_o);
    compare("reset_in_ready", 1'b1, in_ready_o);

    // Random traffic, output readiness alternates between slow and fast
    for (int n = 0; n < random_cycles; n++) begin
      ready_pct = ((n / 250) % 2 == 0) ? 20 : 80;
      step($urandom_range(0, 3) != 0, random_msg(), $urandom_range(0, 99) < ready_pct,
           id_mask_t'($urandom));
    end
    wait_drained('1);

    // Fill every slot with the output stalled
    for (int n = 0; n < capacity; n++) begin
      step(1'b1, random_msg(), 1'b0, '1);
    end
    step(1'b1, random_msg(), 1'b0, '1);
    compare("full_ready", 1'b0, in_ready_o);
    step(1'b0, '0, 1'b1, '1);
    step(1'b0, '0, 1'b0, '1);
    compare("after_pop_ready", 1'b1, in_ready_o);
    wait_drained('1);

    // Highest identifier held back, then released on its own
    for (int n = 0; n < 200; n++) begin
      step($urandom_range(0, 1), random_msg(), 1'b1, ~gated_mask);
      compare("gated_out", 1'b0, out_valid_o && (out_msg_o.id == gated_id));
    end
    wait_drained(gated_mask);
    wait_drained('1);

    // Push and pop on identifier 1 in the same cycle
    msg_a = make_msg(12'h5a1, 2'd1);
    msg_b = make_msg(12'h0b7, 2'd1);
    step(1'b1, msg_a, 1'b0, 4'b0010);
    step(1'b1, msg_b, 1'b1, 4'b0010);
    step(1'b0, '0, 1'b1, 4'b0010);
    compare("same_cycle_valid", 1'b1, out_valid_o);
    compare("same_cycle_msg", msg_b, out_msg_o);
    step(1'b0, '0, 1'b0, '1);
    compare("same_cycle_empty", 1'b0, out_valid_o);

    $display("=== PASS ===");
    $finish;
  end

endmodule
